//--- source/isa_pkg.sv
package isa_pkg;

	localparam int instr_width = 32;

	// Field widths
	localparam int opcode_width = 6;
	localparam int funct_width = 6;
	localparam int reg_addr_width = 5;
	localparam int shamt_width = 5;
	localparam int imm_width = 16;
	localparam int target_width = 26;

	// Field positions, low bit of each field
	localparam int opcode_lsb = 26;
	localparam int rs_lsb = 21;
	localparam int rt_lsb = 16;
	localparam int rd_lsb = 11;
	localparam int shamt_lsb = 6;
	localparam int funct_lsb = 0;
	localparam int imm_lsb = 0;
	localparam int target_lsb = 0;

	// Opcodes
	localparam logic [opcode_width-1:0] rtype = 6'b000000;
	localparam logic [opcode_width-1:0] regimm = 6'b000001;
	localparam logic [opcode_width-1:0] j = 6'b000010;
	localparam logic [opcode_width-1:0] jal = 6'b000011;
	localparam logic [opcode_width-1:0] beq = 6'b000100;
	localparam logic [opcode_width-1:0] bne = 6'b000101;
	localparam logic [opcode_width-1:0] blez = 6'b000110;
	localparam logic [opcode_width-1:0] bgtz = 6'b000111;
	localparam logic [opcode_width-1:0] addi = 6'b001000;
	localparam logic [opcode_width-1:0] addiu = 6'b001001;
	localparam logic [opcode_width-1:0] slti = 6'b001010;
	localparam logic [opcode_width-1:0] sltiu = 6'b001011;
	localparam logic [opcode_width-1:0] ori = 6'b001101;
	localparam logic [opcode_width-1:0] xori = 6'b001110;
	localparam logic [opcode_width-1:0] lui = 6'b001111;
	localparam logic [opcode_width-1:0] mul_op = 6'b011100; // SPECIAL2, MUL only
	localparam logic [opcode_width-1:0] lb = 6'b100000;
	localparam logic [opcode_width-1:0] lw = 6'b100011;
	localparam logic [opcode_width-1:0] lbu = 6'b100100;
	localparam logic [opcode_width-1:0] sb = 6'b101000;
	localparam logic [opcode_width-1:0] sw = 6'b101011;

	// Function codes under rtype
	localparam logic [funct_width-1:0] sll_funct = 6'b000000;
	localparam logic [funct_width-1:0] srl_funct = 6'b000010;
	localparam logic [funct_width-1:0] sra_funct = 6'b000011;
	localparam logic [funct_width-1:0] sllv_funct = 6'b000100;
	localparam logic [funct_width-1:0] srlv_funct = 6'b000110;
	localparam logic [funct_width-1:0] srav_funct = 6'b000111;
	localparam logic [funct_width-1:0] jr_funct = 6'b001000;
	localparam logic [funct_width-1:0] jalr_funct = 6'b001001;
	localparam logic [funct_width-1:0] mfhi_funct = 6'b010000;
	localparam logic [funct_width-1:0] mflo_funct = 6'b010010;
	localparam logic [funct_width-1:0] mult_funct = 6'b011000;
	localparam logic [funct_width-1:0] multu_funct = 6'b011001;
	localparam logic [funct_width-1:0] div_funct = 6'b011010;
	localparam logic [funct_width-1:0] divu_funct = 6'b011011;
	localparam logic [funct_width-1:0] add_funct = 6'b100000;
	localparam logic [funct_width-1:0] addu_funct = 6'b100001;
	localparam logic [funct_width-1:0] sub_funct = 6'b100010;
	localparam logic [funct_width-1:0] subu_funct = 6'b100011;
	localparam logic [funct_width-1:0] and_funct = 6'b100100;
	localparam logic [funct_width-1:0] or_funct = 6'b100101;
	localparam logic [funct_width-1:0] xor_funct = 6'b100110;
	localparam logic [funct_width-1:0] nor_funct = 6'b100111;
	localparam logic [funct_width-1:0] slt_funct = 6'b101010;
	localparam logic [funct_width-1:0] sltu_funct = 6'b101011;
	localparam logic [funct_width-1:0] mul_funct = 6'b000010; // Under mul_op only

	// REGIMM selectors in the rt field
	localparam logic [reg_addr_width-1:0] bltz_sel = 5'b00000;
	localparam logic [reg_addr_width-1:0] bgez_sel = 5'b00001;

	localparam logic [reg_addr_width-1:0] link_reg = 5'd31; // JAL return address

endpackage

//--- source/core_pkg.sv
package core_pkg;

	localparam int data_width = 32;
	localparam int num_regs = 32;

	localparam int stack_pointer_reg = 29;
	localparam logic [data_width-1:0] stack_pointer_init = 32'h8012_0000;

	// One code per decoded instruction
	typedef enum logic [5:0] {
		op_nop,
		op_add, op_addu, op_sub, op_subu,
		op_mul, op_mult, op_multu, op_div, op_divu,
		op_mfhi, op_mflo,
		op_slt, op_sltu,
		op_sll, op_sllv, op_srl, op_srlv, op_sra, op_srav,
		op_and, op_or, op_xor, op_nor,
		op_jalr, op_jr,
		op_addi, op_addiu, op_slti, op_sltiu,
		op_ori, op_xori, op_lui,
		op_lw, op_lb, op_lbu,
		op_sw, op_sb,
		op_beq, op_bne, op_bgtz, op_blez,
		op_bltz, op_bgez,
		op_j, op_jal,
		op_illegal
	} alu_op_t;

endpackage

//--- source/instruction_decoder.sv
`timescale 1ns/1ps

module instruction_decoder (
	input logic [isa_pkg::instr_width-1:0] instr,
	output logic [isa_pkg::opcode_width-1:0] opcode,
	output logic [isa_pkg::funct_width-1:0] funct,
	output logic [isa_pkg::reg_addr_width-1:0] rs,
	output logic [isa_pkg::reg_addr_width-1:0] rt,
	output logic [isa_pkg::reg_addr_width-1:0] rd,
	output logic [isa_pkg::shamt_width-1:0] shamt,
	output logic [core_pkg::data_width-1:0] imm,
	output core_pkg::alu_op_t alu_op,
	output logic illegal
);

	typedef enum logic [1:0] {rd_src_none, rd_src_rd, rd_src_rt, rd_src_link} rd_src_t;
	typedef enum logic [1:0] {imm_src_none, imm_src_sign, imm_src_zero} imm_src_t;

	logic [isa_pkg::opcode_width-1:0] op_field;
	logic [isa_pkg::funct_width-1:0] funct_field;
	logic [isa_pkg::reg_addr_width-1:0] rs_field;
	logic [isa_pkg::reg_addr_width-1:0] rt_field;
	logic [isa_pkg::reg_addr_width-1:0] rd_field;
	logic [isa_pkg::shamt_width-1:0] shamt_field;
	logic [isa_pkg::imm_width-1:0] imm_field;
	logic [isa_pkg::target_width-1:0] target_field;

	core_pkg::alu_op_t op;
	logic use_rs;
	logic use_rt;
	logic use_shamt;
	logic use_funct;
	rd_src_t rd_src;
	imm_src_t imm_src;

	assign op_field = instr[isa_pkg::opcode_lsb +: isa_pkg::opcode_width];
	assign funct_field = instr[isa_pkg::funct_lsb +: isa_pkg::funct_width];
	assign rs_field = instr[isa_pkg::rs_lsb +: isa_pkg::reg_addr_width];
	assign rt_field = instr[isa_pkg::rt_lsb +: isa_pkg::reg_addr_width];
	assign rd_field = instr[isa_pkg::rd_lsb +: isa_pkg::reg_addr_width];
	assign shamt_field = instr[isa_pkg::shamt_lsb +: isa_pkg::shamt_width];
	assign imm_field = instr[isa_pkg::imm_lsb +: isa_pkg::imm_width];
	assign target_field = instr[isa_pkg::target_lsb +: isa_pkg::target_width];

	// Encoding to operation
	always_comb begin
		op = core_pkg::op_illegal;
		case (op_field)
			isa_pkg::rtype: begin
				if (instr == '0) begin
					op = core_pkg::op_nop; // sll r0,r0,0 form
				end else begin
					case (funct_field)
						isa_pkg::add_funct: op = core_pkg::op_add;
						isa_pkg::addu_funct: op = core_pkg::op_addu;
						isa_pkg::sub_funct: op = core_pkg::op_sub;
						isa_pkg::subu_funct: op = core_pkg::op_subu;
						isa_pkg::mult_funct: op = core_pkg::op_mult;
						isa_pkg::multu_funct: op = core_pkg::op_multu;
						isa_pkg::div_funct: op = core_pkg::op_div;
						isa_pkg::divu_funct: op = core_pkg::op_divu;
						isa_pkg::mfhi_funct: op = core_pkg::op_mfhi;
						isa_pkg::mflo_funct: op = core_pkg::op_mflo;
						isa_pkg::slt_funct: op = core_pkg::op_slt;
						isa_pkg::sltu_funct: op = core_pkg::op_sltu;
						isa_pkg::sll_funct: op = core_pkg::op_sll;
						isa_pkg::sllv_funct: op = core_pkg::op_sllv;
						isa_pkg::srl_funct: op = core_pkg::op_srl;
						isa_pkg::srlv_funct: op = core_pkg::op_srlv;
						isa_pkg::sra_funct: op = core_pkg::op_sra;
						isa_pkg::srav_funct: op = core_pkg::op_srav;
						isa_pkg::and_funct: op = core_pkg::op_and;
						isa_pkg::or_funct: op = core_pkg::op_or;
						isa_pkg::xor_funct: op = core_pkg::op_xor;
						isa_pkg::nor_funct: op = core_pkg::op_nor;
						isa_pkg::jalr_funct: op = core_pkg::op_jalr;
						isa_pkg::jr_funct: op = core_pkg::op_jr;
						default: op = core_pkg::op_illegal;
					endcase
				end
			end
			isa_pkg::mul_op: begin
				if (funct_field == isa_pkg::mul_funct) begin
					op = core_pkg::op_mul; // Same funct as srl, told apart by opcode
				end
			end
			isa_pkg::regimm: begin
				case (rt_field)
					isa_pkg::bltz_sel: op = core_pkg::op_bltz;
					isa_pkg::bgez_sel: op = core_pkg::op_bgez;
					default: op = core_pkg::op_illegal;
				endcase
			end
			isa_pkg::j: op = core_pkg::op_j;
			isa_pkg::jal: op = core_pkg::op_jal;
			isa_pkg::addi: op = core_pkg::op_addi;
			isa_pkg::addiu: op = core_pkg::op_addiu;
			isa_pkg::slti: op = core_pkg::op_slti;
			isa_pkg::sltiu: op = core_pkg::op_sltiu;
			isa_pkg::ori: op = core_pkg::op_ori;
			isa_pkg::xori: op = core_pkg::op_xori;
			isa_pkg::lui: op = core_pkg::op_lui;
			isa_pkg::lw: op = core_pkg::op_lw;
			isa_pkg::lb: op = core_pkg::op_lb;
			isa_pkg::lbu: op = core_pkg::op_lbu;
			isa_pkg::sw: op = core_pkg::op_sw;
			isa_pkg::sb: op = core_pkg::op_sb;
			isa_pkg::beq: op = core_pkg::op_beq;
			isa_pkg::bne: op = core_pkg::op_bne;
			isa_pkg::bgtz: op = core_pkg::op_bgtz;
			isa_pkg::blez: op = core_pkg::op_blez;
			default: op = core_pkg::op_illegal;
		endcase
	end

	// Which fields each operation carries
	always_comb begin
		use_rs = 1'b0;
		use_rt = 1'b0;
		use_shamt = 1'b0;
		use_funct = 1'b0;
		rd_src = rd_src_none;
		imm_src = imm_src_none;
		case (op)
			core_pkg::op_add, core_pkg::op_addu, core_pkg::op_sub, core_pkg::op_subu,
			core_pkg::op_mul, core_pkg::op_slt, core_pkg::op_sltu,
			core_pkg::op_sllv, core_pkg::op_srlv, core_pkg::op_srav,
			core_pkg::op_and, core_pkg::op_or, core_pkg::op_xor, core_pkg::op_nor,
			core_pkg::op_jalr: begin
				use_rs = 1'b1;
				use_rt = 1'b1;
				use_funct = 1'b1;
				rd_src = rd_src_rd;
			end
			core_pkg::op_mult, core_pkg::op_multu, core_pkg::op_div, core_pkg::op_divu: begin
				use_rs = 1'b1; // Result goes to hi/lo
				use_rt = 1'b1;
				use_funct = 1'b1;
			end
			core_pkg::op_mfhi, core_pkg::op_mflo: begin
				use_funct = 1'b1;
				rd_src = rd_src_rd;
			end
			core_pkg::op_sll, core_pkg::op_srl, core_pkg::op_sra: begin
				use_rt = 1'b1;
				use_shamt = 1'b1;
				use_funct = 1'b1;
				rd_src = rd_src_rd;
			end
			core_pkg::op_jr: begin
				use_rs = 1'b1;
				use_funct = 1'b1;
			end
			core_pkg::op_addi, core_pkg::op_addiu, core_pkg::op_slti, core_pkg::op_sltiu,
			core_pkg::op_ori, core_pkg::op_xori,
			core_pkg::op_lw, core_pkg::op_lb, core_pkg::op_lbu: begin
				use_rs = 1'b1;
				use_rt = 1'b1;
				rd_src = rd_src_rt;
				imm_src = imm_src_sign;
			end
			core_pkg::op_lui: begin
				use_rt = 1'b1;
				rd_src = rd_src_rt;
				imm_src = imm_src_sign;
			end
			core_pkg::op_sw, core_pkg::op_sb,
			core_pkg::op_beq, core_pkg::op_bne, core_pkg::op_bgtz, core_pkg::op_blez,
			core_pkg::op_bltz, core_pkg::op_bgez: begin
				use_rs = 1'b1;
				use_rt = 1'b1; // Selector value for REGIMM
				imm_src = imm_src_sign;
			end
			core_pkg::op_j: imm_src = imm_src_zero;
			core_pkg::op_jal: begin
				rd_src = rd_src_link;
				imm_src = imm_src_zero;
			end
			default: begin
				use_rs = 1'b0; // nop and illegal carry no fields
			end
		endcase
	end

	assign alu_op = op;
	assign illegal = (op == core_pkg::op_illegal);
	assign opcode = illegal ? '0 : op_field;
	assign funct = use_funct ? funct_field : '0;
	assign rs = use_rs ? rs_field : '0;
	assign rt = use_rt ? rt_field : '0;
	assign shamt = use_shamt ? shamt_field : '0;

	always_comb begin
		case (rd_src)
			rd_src_rd: rd = rd_field;
			rd_src_rt: rd = rt_field;
			rd_src_link: rd = isa_pkg::link_reg;
			default: rd = '0;
		endcase
	end

	always_comb begin
		case (imm_src)
			imm_src_sign: imm = {{(core_pkg::data_width - isa_pkg::imm_width)
				{imm_field[isa_pkg::imm_width-1]}}, imm_field};
			imm_src_zero: imm = {{(core_pkg::data_width - isa_pkg::target_width){1'b0}},
				target_field};
			default: imm = '0;
		endcase
	end

endmodule

//--- source/register_file.sv
`timescale 1ns/1ps

module register_file (
	input logic clock,
	input logic reset,
	input logic [isa_pkg::reg_addr_width-1:0] read_addr_a,
	input logic [isa_pkg::reg_addr_width-1:0] read_addr_b,
	output logic [core_pkg::data_width-1:0] read_data_a,
	output logic [core_pkg::data_width-1:0] read_data_b,
	input logic write_enable,
	input logic [isa_pkg::reg_addr_width-1:0] write_addr,
	input logic [core_pkg::data_width-1:0] write_data
);

	logic [core_pkg::data_width-1:0] regs [core_pkg::num_regs];

	// Reset preloads register i with i, sp with its start address
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < core_pkg::num_regs; i++) begin
				if (i == core_pkg::stack_pointer_reg) begin
					regs[i] <= core_pkg::stack_pointer_init;
				end else begin
					regs[i] <= core_pkg::data_width'(i);
				end
			end
		end else if (write_enable && write_addr != '0) begin
			regs[write_addr] <= write_data; // r0 stays hardwired
		end
	end

	assign read_data_a = (read_addr_a == '0) ? '0 : regs[read_addr_a];
	assign read_data_b = (read_addr_b == '0) ? '0 : regs[read_addr_b];

endmodule

//--- source/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
	input logic clock,
	input logic reset,
	input logic [isa_pkg::instr_width-1:0] instr,
	input logic [core_pkg::data_width-1:0] pc,
	input logic decode_enable,
	input logic write_enable,
	input logic [isa_pkg::reg_addr_width-1:0] write_addr,
	input logic [core_pkg::data_width-1:0] write_data,
	output logic [isa_pkg::opcode_width-1:0] opcode,
	output logic [isa_pkg::funct_width-1:0] funct,
	output logic [isa_pkg::reg_addr_width-1:0] rs,
	output logic [isa_pkg::reg_addr_width-1:0] rt,
	output logic [isa_pkg::reg_addr_width-1:0] rd,
	output logic [isa_pkg::shamt_width-1:0] shamt,
	output logic [core_pkg::data_width-1:0] imm,
	output core_pkg::alu_op_t alu_op,
	output logic illegal,
	output logic [core_pkg::data_width-1:0] pc_out,
	output logic [core_pkg::data_width-1:0] rs_data,
	output logic [core_pkg::data_width-1:0] rt_data
);

	logic [isa_pkg::opcode_width-1:0] dec_opcode;
	logic [isa_pkg::funct_width-1:0] dec_funct;
	logic [isa_pkg::reg_addr_width-1:0] dec_rs;
	logic [isa_pkg::reg_addr_width-1:0] dec_rt;
	logic [isa_pkg::reg_addr_width-1:0] dec_rd;
	logic [isa_pkg::shamt_width-1:0] dec_shamt;
	logic [core_pkg::data_width-1:0] dec_imm;
	core_pkg::alu_op_t dec_alu_op;
	logic dec_illegal;

	instruction_decoder instruction_decoder_inst (
		.instr(instr),
		.opcode(dec_opcode),
		.funct(dec_funct),
		.rs(dec_rs),
		.rt(dec_rt),
		.rd(dec_rd),
		.shamt(dec_shamt),
		.imm(dec_imm),
		.alu_op(dec_alu_op),
		.illegal(dec_illegal)
	);

	// Decode outputs, one cycle after the enable edge
	always_ff @(posedge clock) begin
		if (reset) begin
			opcode <= '0;
			funct <= '0;
			rs <= '0;
			rt <= '0;
			rd <= '0;
			shamt <= '0;
			imm <= '0;
			alu_op <= core_pkg::op_nop;
			illegal <= 1'b0;
			pc_out <= '0;
		end else if (decode_enable) begin
			opcode <= dec_opcode;
			funct <= dec_funct;
			rs <= dec_rs;
			rt <= dec_rt;
			rd <= dec_rd;
			shamt <= dec_shamt;
			imm <= dec_imm;
			alu_op <= dec_alu_op;
			illegal <= dec_illegal;
			pc_out <= pc;
		end
	end

	// Operands read from the captured addresses
	register_file register_file_inst (
		.clock(clock),
		.reset(reset),
		.read_addr_a(rs),
		.read_addr_b(rt),
		.read_data_a(rs_data),
		.read_data_b(rt_data),
		.write_enable(write_enable),
		.write_addr(write_addr),
		.write_data(write_data)
	);

endmodule

//--- tests/decode_model.svh
typedef struct packed {
	logic [isa_pkg::opcode_width-1:0] opcode;
	logic [isa_pkg::funct_width-1:0] funct;
	logic [isa_pkg::reg_addr_width-1:0] rs, rt, rd;
	logic [isa_pkg::shamt_width-1:0] shamt;
	logic [core_pkg::data_width-1:0] imm;
	core_pkg::alu_op_t alu_op;
	logic illegal;
} decode_t;

localparam logic [isa_pkg::funct_width-1:0] rtype_functs [24] = '{
	isa_pkg::add_funct, isa_pkg::addu_funct, isa_pkg::sub_funct, isa_pkg::subu_funct,
	isa_pkg::mult_funct, isa_pkg::multu_funct, isa_pkg::div_funct, isa_pkg::divu_funct,
	isa_pkg::mfhi_funct, isa_pkg::mflo_funct, isa_pkg::slt_funct, isa_pkg::sltu_funct,
	isa_pkg::sll_funct, isa_pkg::sllv_funct, isa_pkg::srl_funct, isa_pkg::srlv_funct,
	isa_pkg::sra_funct, isa_pkg::srav_funct, isa_pkg::and_funct, isa_pkg::or_funct,
	isa_pkg::xor_funct, isa_pkg::nor_funct, isa_pkg::jalr_funct, isa_pkg::jr_funct};
localparam core_pkg::alu_op_t rtype_ops [24] = '{
	core_pkg::op_add, core_pkg::op_addu, core_pkg::op_sub, core_pkg::op_subu,
	core_pkg::op_mult, core_pkg::op_multu, core_pkg::op_div, core_pkg::op_divu,
	core_pkg::op_mfhi, core_pkg::op_mflo, core_pkg::op_slt, core_pkg::op_sltu,
	core_pkg::op_sll, core_pkg::op_sllv, core_pkg::op_srl, core_pkg::op_srlv,
	core_pkg::op_sra, core_pkg::op_srav, core_pkg::op_and, core_pkg::op_or,
	core_pkg::op_xor, core_pkg::op_nor, core_pkg::op_jalr, core_pkg::op_jr};

// First ten write rt, the rest are stores and branches
localparam logic [isa_pkg::opcode_width-1:0] itype_opcodes [16] = '{
	isa_pkg::addi, isa_pkg::addiu, isa_pkg::slti, isa_pkg::sltiu, isa_pkg::ori,
	isa_pkg::xori, isa_pkg::lui, isa_pkg::lw, isa_pkg::lb, isa_pkg::lbu,
	isa_pkg::sw, isa_pkg::sb, isa_pkg::beq, isa_pkg::bne, isa_pkg::bgtz, isa_pkg::blez};
localparam core_pkg::alu_op_t itype_ops [16] = '{
	core_pkg::op_addi, core_pkg::op_addiu, core_pkg::op_slti, core_pkg::op_sltiu,
	core_pkg::op_ori, core_pkg::op_xori, core_pkg::op_lui, core_pkg::op_lw,
	core_pkg::op_lb, core_pkg::op_lbu, core_pkg::op_sw, core_pkg::op_sb,
	core_pkg::op_beq, core_pkg::op_bne, core_pkg::op_bgtz, core_pkg::op_blez};

logic [31:0] lfsr_state = 32'hab17_cf43;

// Taps 32 22 2 1
function automatic logic [31:0] lfsr_bits(input int count);
	logic [31:0] value;
	logic feedback;
	value = '0;
	for (int b = 0; b < count; b++) begin
		feedback = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], feedback};
		value = {value[30:0], feedback};
	end
	return value;
endfunction

function automatic decode_t expected_decode(input logic [31:0] word);
	decode_t d;
	logic [5:0] op_bits;
	logic [4:0] t;
	d = '0;
	op_bits = word[31:26];
	t = word[20:16];
	if (word == '0) begin
		return d; // nop
	end
	d.alu_op = core_pkg::op_illegal;
	d.rs = word[25:21];
	d.rt = t;
	if (op_bits == isa_pkg::rtype || op_bits == isa_pkg::mul_op) begin
		for (int k = 0; k < 24; k++) begin
			if (op_bits == isa_pkg::rtype && word[5:0] == rtype_functs[k]) d.alu_op = rtype_ops[k];
		end
		if (op_bits == isa_pkg::mul_op && word[5:0] == isa_pkg::mul_funct) d.alu_op = core_pkg::op_mul;
		d.funct = word[5:0];
		d.rd = word[15:11];
		case (d.alu_op)
			core_pkg::op_mult, core_pkg::op_multu, core_pkg::op_div, core_pkg::op_divu: begin
				d.rd = '0; // hi/lo destination
			end
			core_pkg::op_jr: begin
				d.rt = '0;
				d.rd = '0;
			end
			core_pkg::op_mfhi, core_pkg::op_mflo: begin
				d.rs = '0;
				d.rt = '0;
			end
			core_pkg::op_sll, core_pkg::op_srl, core_pkg::op_sra: begin
				d.rs = '0;
				d.shamt = word[10:6];
			end
			default: ;
		endcase
	end else if (op_bits == isa_pkg::regimm) begin
		if (t == isa_pkg::bltz_sel) d.alu_op = core_pkg::op_bltz;
		if (t == isa_pkg::bgez_sel) d.alu_op = core_pkg::op_bgez;
		d.imm = {{16{word[15]}}, word[15:0]};
	end else if (op_bits == isa_pkg::j || op_bits == isa_pkg::jal) begin
		d.alu_op = (op_bits == isa_pkg::jal) ? core_pkg::op_jal : core_pkg::op_j;
		d.rd = (op_bits == isa_pkg::jal) ? isa_pkg::link_reg : '0;
		d.rs = '0;
		d.rt = '0;
		d.imm = {6'b0, word[25:0]};
	end else begin
		for (int k = 0; k < 16; k++) begin
			if (op_bits == itype_opcodes[k]) begin
				d.alu_op = itype_ops[k];
				d.rd = (k < 10) ? t : '0;
			end
		end
		if (d.alu_op == core_pkg::op_lui) d.rs = '0;
		d.imm = {{16{word[15]}}, word[15:0]};
	end
	if (d.alu_op == core_pkg::op_illegal) begin
		d = '0;
		d.alu_op = core_pkg::op_illegal;
		d.illegal = 1'b1;
	end else begin
		d.opcode = op_bits;
	end
	return d;
endfunction

//--- tests/decode_stage_tb.sv
`timescale 1ns/1ps

module decode_stage_tb;

	logic clock, reset, decode_enable, write_enable, illegal;
	logic [isa_pkg::instr_width-1:0] instr;
	logic [core_pkg::data_width-1:0] pc, write_data, imm, pc_out, rs_data, rt_data;
	logic [isa_pkg::opcode_width-1:0] opcode;
	logic [isa_pkg::funct_width-1:0] funct;
	logic [isa_pkg::reg_addr_width-1:0] write_addr, rs, rt, rd;
	logic [isa_pkg::shamt_width-1:0] shamt;
	core_pkg::alu_op_t alu_op;
	logic [core_pkg::data_width-1:0] shadow [core_pkg::num_regs];
	int errors = 0;
	int cycles = 0;

	`include "decode_model.svh"

	decode_stage decode_stage_inst (.*);

	always #4 clock = ~clock;

	// Tests need about 530 cycles
	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles == 3000) begin
			$display("Timeout, the tests did not finish within %0d cycles", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			errors++;
			$display("Fail %0t %s expected %h actual %h", $time, name, expected, actual);
		end
	endtask

	task automatic check_outputs(input decode_t want, input logic [31:0] pc_value);
		check_value("opcode", 32'(want.opcode), 32'(opcode));
		check_value("funct", 32'(want.funct), 32'(funct));
		check_value("rs", 32'(want.rs), 32'(rs));
		check_value("rt", 32'(want.rt), 32'(rt));
		check_value("rd", 32'(want.rd), 32'(rd));
		check_value("shamt", 32'(want.shamt), 32'(shamt));
		check_value("imm", want.imm, imm);
		check_value("alu_op", 32'(want.alu_op), 32'(alu_op));
		check_value("illegal", 32'(want.illegal), 32'(illegal));
		check_value("pc_out", pc_value, pc_out);
		check_value("rs_data", shadow[want.rs], rs_data);
		check_value("rt_data", shadow[want.rt], rt_data);
	endtask

	task automatic decode_and_check(input logic [31:0] word, input logic [31:0] pc_value);
		@(posedge clock);
		instr <= word;
		pc <= pc_value;
		decode_enable <= 1'b1;
		@(posedge clock);
		decode_enable <= 1'b0;
		instr <= ~word; // Not captured
		@(negedge clock);
		check_outputs(expected_decode(word), pc_value);
	endtask

	task automatic reset_test();
		check_outputs('0, '0); // op_nop, all zero
		decode_and_check({isa_pkg::rtype, 5'd0, 5'd5, 5'd1, 5'd0, isa_pkg::add_funct}, 32'h400);
		check_value("rt_data", 32'd5, rt_data);
		decode_and_check({isa_pkg::rtype, 5'd29, 5'd0, 5'd1, 5'd0, isa_pkg::add_funct}, 32'h404);
		check_value("rs_data", core_pkg::stack_pointer_init, rs_data);
	endtask

	task automatic rtype_test();
		logic [31:0] word;
		logic [31:0] pc_value;
		for (int k = 0; k < 50; k++) begin
			if (k % 25 == 24) word = {isa_pkg::mul_op, 20'(lfsr_bits(20)), isa_pkg::mul_funct};
			else word = {isa_pkg::rtype, 20'(lfsr_bits(20)), rtype_functs[k % 25]};
			pc_value = lfsr_bits(32);
			decode_and_check(word, pc_value);
			repeat (2) @(posedge clock); // Enable low, outputs hold
			@(negedge clock);
			check_outputs(expected_decode(word), pc_value);
		end
	endtask

	task automatic itype_test();
		logic [31:0] word;
		for (int k = 0; k < 64; k++) begin
			word = {itype_opcodes[k / 4], 26'(lfsr_bits(26))};
			word[15] = k[0];
			decode_and_check(word, lfsr_bits(32));
		end
	endtask

	task automatic branch_jump_test();
		logic [31:0] words [6];
		words[0] = '0;
		words[1] = {isa_pkg::regimm, 5'(lfsr_bits(5)), isa_pkg::bltz_sel, 16'(lfsr_bits(16))};
		words[2] = {isa_pkg::regimm, 5'(lfsr_bits(5)), isa_pkg::bgez_sel, 16'h8000};
		words[3] = {isa_pkg::j, 26'h3ff_ffff};
		words[4] = {isa_pkg::j, 26'(lfsr_bits(26))};
		words[5] = {isa_pkg::jal, 26'(lfsr_bits(26))};
		foreach (words[n]) decode_and_check(words[n], lfsr_bits(32));
		check_value("rd", 32'(isa_pkg::link_reg), 32'(rd));
	endtask

	task automatic illegal_test();
		logic [31:0] words [8];
		words[0] = {6'b010000, 26'(lfsr_bits(26))};
		words[1] = {6'b011101, 26'(lfsr_bits(26))};
		words[2] = {6'b111111, 26'(lfsr_bits(26))};
		words[3] = {isa_pkg::rtype, 20'(lfsr_bits(20)), 6'b000001};
		words[4] = {isa_pkg::rtype, 20'(lfsr_bits(20)), 6'b010001};
		words[5] = {isa_pkg::rtype, 20'(lfsr_bits(20)), 6'b111111};
		words[6] = {isa_pkg::mul_op, 20'(lfsr_bits(20)), 6'b000000};
		words[7] = {isa_pkg::regimm, 5'(lfsr_bits(5)), 5'b00010, 16'(lfsr_bits(16))};
		foreach (words[n]) begin
			decode_and_check(words[n], lfsr_bits(32));
			check_value("illegal", 32'd1, 32'(illegal));
		end
	endtask

	task automatic regfile_test();
		logic [4:0] a;
		logic [4:0] b;
		logic [31:0] value;
		b = '0;
		for (int n = 0; n < 40; n++) begin
			a = (n % 8 == 3) ? '0 : 5'(lfsr_bits(5));
			value = lfsr_bits(32);
			@(posedge clock);
			write_enable <= 1'b1;
			write_addr <= a;
			write_data <= value;
			@(posedge clock);
			write_enable <= 1'b0;
			if (a != '0) shadow[a] = value;
			decode_and_check({isa_pkg::rtype, a, b, 5'(lfsr_bits(5)), 5'd0, isa_pkg::or_funct},
				lfsr_bits(32));
			if (a == '0) check_value("rs_data", '0, rs_data);
			b = a;
		end
	endtask

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		decode_enable = 1'b0;
		write_enable = 1'b0;
		instr = '0;
		pc = '0;
		write_addr = '0;
		write_data = '0;
		for (int i = 0; i < core_pkg::num_regs; i++) begin
			shadow[i] = 32'(i);
		end
		shadow[core_pkg::stack_pointer_reg] = core_pkg::stack_pointer_init;
		repeat (5) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		reset_test();
		rtype_test();
		itype_test();
		branch_jump_test();
		illegal_test();
		regfile_test();
		$display("Run complete after %0d cycles with %0d errors", cycles, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- src.f
+incdir+tests
source/isa_pkg.sv
source/core_pkg.sv
source/instruction_decoder.sv
source/register_file.sv
source/decode_stage.sv
tests/decode_stage_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module decode_stage_tb -f src.f -Mdir obj_dir \
	&& ./obj_dir/Vdecode_stage_tb > sim.log 2>&1 \
	|| echo "TEST FAILED: build or simulation error" >> sim.log
cat sim.log
! grep -q "TEST FAILED" sim.log && grep -q "TEST PASSED" sim.log
